//--- rtl/ql_io_params.svh
`ifndef QL_IO_PARAMS_SVH
`define QL_IO_PARAMS_SVH

// ========================================
// Bus geometry
// ========================================
`define QL_IO_ADDR_W      7         // Byte address inside the I/O window
`define QL_DATA_W         16        // 68000 data bus
`define QL_KBD_W          64        // 8 rows x 8 columns

// One-second prescale, CPU clock ticks
`define QL_CLK_HZ         27000000

// ========================================
// Word offsets in the peripheral window
// ========================================
`define QL_OFS_TIMER      0         // $18000..$18003
`define QL_OFS_IPC        1         // $18003
`define QL_OFS_IRQ        16        // $18020/21
`define QL_OFS_DISPLAY    49        // $18063

// Pending / acknowledge bit positions
`define QL_IRQ_VSYNC_BIT  3
`define QL_IRQ_TIMER_BIT  5

`define QL_REPLY_W        16        // IPC return shift register

`endif

//--- rtl/ql_io_pkg.sv
`default_nettype none

package ql_io_pkg;

  // IPC opcodes as sent by QDOS, MSB first
  typedef enum logic [3:0] {
    cmd_init       = 4'd0,
    cmd_status     = 4'd1,   // Get status
    cmd_ser1_open  = 4'd2,
    cmd_ser2_open  = 4'd3,
    cmd_ser1_close = 4'd4,
    cmd_ser2_close = 4'd5,
    cmd_ser1_read  = 4'd6,
    cmd_ser2_read  = 4'd7,
    cmd_key        = 4'd8,   // Read key
    cmd_keyrow     = 4'd9,   // Read key row, takes a parameter nibble
    cmd_sound_set  = 4'd10,
    cmd_sound_kill = 4'd11,
    cmd_set_ipl    = 4'd12,
    cmd_baud       = 4'd13,
    cmd_random     = 4'd14,
    cmd_test       = 4'd15
  } ipc_cmd_e;

  // Serial engine phases
  typedef enum logic [1:0] {
    st_idle  = 2'd0,         // Collecting a command nibble
    st_reply = 2'd1,         // Shifting out the return register
    st_param = 2'd2          // Collecting a parameter nibble
  } ipc_state_e;

endpackage

`default_nettype wire

//--- rtl/ql_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "ql_io_params.svh"

module ql_bus_decode (
  input  logic                     clk_cpu,
  input  logic                     reset,
  input  logic                     i_req,
  input  logic                     i_wr,
  input  logic [`QL_IO_ADDR_W-1:0] i_addr,
  input  logic [1:0]               i_be,        // [1] upper, [0] lower byte
  input  logic [`QL_DATA_W-1:0]    i_wdata,
  input  logic [31:0]              i_count,
  input  logic [7:0]               i_pending,
  input  logic                     i_reply_bit,
  output logic                     o_timer_clr,
  output logic                     o_timer_adj,
  output logic                     o_irq_ack,
  output logic                     o_ipc_wr,
  output logic [7:0]               o_wbyte,
  output logic                     o_wbit,
  output logic                     o_ack,
  output logic [`QL_DATA_W-1:0]    o_rdata,
  output logic                     o_mode
);
  import ql_io_pkg::*;

  localparam int OFS_W = `QL_IO_ADDR_W - 1;

  logic [OFS_W-1:0]      word_ofs;
  logic                  is_timer, is_ipc, is_irq, is_display;
  logic                  is_count;   // Timer long word for reads
  logic                  wr;
  logic [`QL_DATA_W-1:0] rd_mux;

  // ========================================
  // Offset decode and write strobes
  // ========================================
  assign word_ofs   = i_addr[`QL_IO_ADDR_W-1:1];   // Drop the byte bit
  assign is_timer   = word_ofs == OFS_W'(`QL_OFS_TIMER);
  assign is_ipc     = word_ofs == OFS_W'(`QL_OFS_IPC);
  assign is_irq     = word_ofs == OFS_W'(`QL_OFS_IRQ);
  assign is_display = word_ofs == OFS_W'(`QL_OFS_DISPLAY);
  assign is_count   = (word_ofs >> 1) == OFS_W'(`QL_OFS_TIMER >> 1);   // $18000..$18003

  assign wr = i_req & i_wr;

  assign o_timer_clr = wr & is_timer & i_be[1];   // $18000
  assign o_timer_adj = wr & is_timer & i_be[0];   // $18001
  assign o_ipc_wr    = wr & is_ipc & i_be[0];     // $18003
  assign o_irq_ack   = wr & is_irq & i_be[0];     // $18021

  assign o_wbyte = i_wdata[7:0];
  assign o_wbit  = i_wdata[1];                    // IPC data rides on bit 1

  // Read mux
  always_comb begin
    rd_mux = '0;
    if (is_count)
      rd_mux = i_addr[1] ? i_count[15:0] : i_count[31:16];   // $18002 low half
    else if (is_irq)
      rd_mux = {i_reply_bit, 7'b0, i_pending};   // IPC status over pending
  end

  // ========================================
  // Acknowledge and display mode
  // ========================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      o_ack  <= 1'b0;
      o_mode <= 1'b1;         // 256x256 out of reset
    end else begin
      o_ack <= i_req;         // Always one cycle later
      if (wr && is_display)
        o_mode <= i_wdata[3];
    end
  end

  // Read data lines up with the acknowledge, zero on writes
  always_ff @(posedge clk_cpu) begin
    o_rdata <= (i_req && !i_wr) ? rd_mux : '0;
  end

endmodule

`default_nettype wire

//--- rtl/ql_rtc.sv
`timescale 1ns/1ps
`default_nettype none
`include "ql_io_params.svh"

module ql_rtc #(
  parameter int PRESCALE = `QL_CLK_HZ
) (
  input  logic        clk_cpu,
  input  logic        reset,
  input  logic        i_timer_clr,   // Zero count and byte index
  input  logic        i_timer_adj,   // Replace one count byte
  input  logic [7:0]  i_wbyte,
  output logic [31:0] o_count        // Seconds
);
  import ql_io_pkg::*;

  localparam int PS_W = $clog2(PRESCALE + 1);

  logic [PS_W-1:0] prescaler;
  logic [1:0]      byte_idx;         // Next byte to adjust, 0 = bits 7:0
  logic            tick;

  assign tick = prescaler == PS_W'(PRESCALE - 1);   // One second gone

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      prescaler <= '0;
      o_count   <= '0;
      byte_idx  <= '0;
    end else begin
      prescaler <= tick ? '0 : prescaler + 1'b1;
      if (i_timer_clr) begin      // Clear beats adjust
        o_count  <= '0;
        byte_idx <= '0;
      end else if (i_timer_adj) begin
        o_count[{byte_idx, 3'b000} +: 8] <= i_wbyte;
        byte_idx <= byte_idx + 1'b1;
      end else if (tick) begin
        o_count <= o_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/ql_irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "ql_io_params.svh"

module ql_irq_ctrl (
  input  logic       clk_cpu,
  input  logic       reset,
  input  logic       i_vsync,       // Raw, from the video side
  input  logic       i_irq_ack,
  input  logic [7:0] i_wbyte,
  input  logic       i_timer_lsb,
  output logic [7:0] o_pending,
  output logic       o_irq
);
  import ql_io_pkg::*;

  logic vsync_s;      // Sync stage
  logic vsync_d;      // Previous synced level
  logic vsync_fall;
  logic vsync_pend;

  always_ff @(posedge clk_cpu) begin
    vsync_s <= i_vsync;
    vsync_d <= vsync_s;
  end

  assign vsync_fall = vsync_d & ~vsync_s;

  // Pending until software acks bit 3
  always_ff @(posedge clk_cpu) begin
    if (reset)
      vsync_pend <= 1'b0;
    else if (i_irq_ack && i_wbyte[`QL_IRQ_VSYNC_BIT])
      vsync_pend <= 1'b0;       // Ack wins over a new edge
    else if (vsync_fall)
      vsync_pend <= 1'b1;
  end

  always_comb begin
    o_pending = '0;
    o_pending[`QL_IRQ_VSYNC_BIT] = vsync_pend;
    o_pending[`QL_IRQ_TIMER_BIT] = i_timer_lsb;   // Free-running, no ack
  end

  assign o_irq = vsync_pend;

endmodule

`default_nettype wire

//--- rtl/ql_ipc.sv
`timescale 1ns/1ps
`default_nettype none
`include "ql_io_params.svh"

module ql_ipc (
  input  logic       clk_cpu,
  input  logic       reset,
  input  logic       i_ipc_wr,      // One strobe per serial bit
  input  logic       i_wbit,
  input  logic [2:0] i_key_row,
  input  logic [2:0] i_key_col,
  input  logic       i_shift,
  input  logic       i_ctrl,
  input  logic       i_alt,
  input  logic       i_any_key,
  input  logic [7:0] i_row_byte,
  output logic       o_reply_bit,
  output logic [2:0] o_row_sel
);
  import ql_io_pkg::*;

  ipc_state_e             state;
  ipc_cmd_e               cmd;
  logic [3:0]             nibble;     // Last bits received, MSB first
  logic [3:0]             nib_next;
  logic [3:0]             bit_cnt;
  logic [3:0]             reply_len;  // Bits to shift out
  logic [`QL_REPLY_W-1:0] ret_q;

  assign nib_next = {nibble[2:0], i_wbit};
  assign cmd      = ipc_cmd_e'(nib_next);

  // Row select includes the bit on the bus so the 4th param write sees it
  assign o_row_sel   = nib_next[2:0];
  assign o_reply_bit = ret_q[`QL_REPLY_W-1];

  // ========================================
  // Serial engine
  // ========================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state     <= st_idle;
      nibble    <= '0;
      bit_cnt   <= '0;
      reply_len <= '0;
      ret_q     <= '0;
    end else if (i_ipc_wr) begin
      nibble <= nib_next;
      case (state)
        st_idle: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'd3) begin        // Full command nibble
            bit_cnt <= '0;
            case (cmd)
              cmd_status: begin
                state     <= st_reply;
                reply_len <= 4'd8;
                ret_q     <= {i_any_key, 15'b0};
              end
              cmd_key: begin
                state     <= st_reply;
                reply_len <= 4'd12;
                ret_q     <= {1'b0, i_shift, i_ctrl, i_alt, 2'b00,
                              i_key_row, i_key_col, 4'b0000};
              end
              cmd_keyrow: state <= st_param;  // Row number follows
              default: ;                      // Accepted, no reply
            endcase
          end
        end
        st_param: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'd3) begin
            state     <= st_reply;
            bit_cnt   <= '0;
            reply_len <= 4'd8;
            ret_q     <= {i_row_byte, 8'b0};
          end
        end
        st_reply: begin
          ret_q <= {ret_q[`QL_REPLY_W-2:0], 1'b0};   // Next bit to bit 15
          if (bit_cnt == reply_len - 1'b1) begin
            state   <= st_idle;
            bit_cnt <= '0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: begin
          state   <= st_idle;
          bit_cnt <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/ql_key_encoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "ql_io_params.svh"

module ql_key_encoder (
  input  logic [`QL_KBD_W-1:0] i_kbd_matrix,   // Bit row*8+column
  input  logic [2:0]           i_row_sel,
  output logic [2:0]           o_key_row,
  output logic [2:0]           o_key_col,
  output logic                 o_shift,
  output logic                 o_ctrl,
  output logic                 o_alt,
  output logic                 o_any_key,
  output logic [7:0]           o_row_byte
);
  import ql_io_pkg::*;

  logic [7:0] hit_row;   // Row picked by the priority encoder

  // Lowest active row among 0..6, else 7
  always_comb begin
    o_key_row = 3'd7;
    for (int r = 6; r >= 0; r--)
      if (|i_kbd_matrix[r*8 +: 8])
        o_key_row = 3'(r);
  end

  assign hit_row = i_kbd_matrix[{o_key_row, 3'b000} +: 8];

  // Lowest set column, 7 when none below it
  always_comb begin
    o_key_col = 3'd7;
    for (int c = 6; c >= 0; c--)
      if (hit_row[c])
        o_key_col = 3'(c);
  end

  assign o_shift    = i_kbd_matrix[56];
  assign o_ctrl     = i_kbd_matrix[57];
  assign o_alt      = i_kbd_matrix[58];
  assign o_any_key  = |i_kbd_matrix;
  assign o_row_byte = i_kbd_matrix[{i_row_sel, 3'b000} +: 8];   // For read key row

endmodule

`default_nettype wire

//--- rtl/ql_io_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "ql_io_params.svh"

module ql_io_top #(
  parameter int PRESCALE = `QL_CLK_HZ   // Ticks per counter second
) (
  input  logic                     clk_cpu,
  input  logic                     reset,
  input  logic                     i_req,
  input  logic                     i_wr,
  input  logic [`QL_IO_ADDR_W-1:0] i_addr,
  input  logic [1:0]               i_be,
  input  logic [`QL_DATA_W-1:0]    i_wdata,
  input  logic                     i_vsync,
  input  logic [`QL_KBD_W-1:0]     i_kbd_matrix,
  output logic                     o_ack,
  output logic [`QL_DATA_W-1:0]    o_rdata,
  output logic                     o_irq,
  output logic                     o_mode
);
  import ql_io_pkg::*;

  // ========================================
  // Internal strobes and return paths
  // ========================================
  logic        timer_clr;
  logic        timer_adj;
  logic        irq_ack;
  logic        ipc_wr;
  logic [7:0]  wbyte;      // Low data byte of the write
  logic        wbit;       // IPC serial bit
  logic [31:0] count;
  logic [7:0]  pending;
  logic        reply_bit;

  // Keyboard encoder <-> IPC
  logic [2:0]  row_sel;
  logic [2:0]  key_row;
  logic [2:0]  key_col;
  logic        key_shift;
  logic        key_ctrl;
  logic        key_alt;
  logic        any_key;
  logic [7:0]  row_byte;

  ql_bus_decode ql_bus_decode_inst (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_req       (i_req),
    .i_wr        (i_wr),
    .i_addr      (i_addr),
    .i_be        (i_be),
    .i_wdata     (i_wdata),
    .i_count     (count),
    .i_pending   (pending),
    .i_reply_bit (reply_bit),
    .o_timer_clr (timer_clr),
    .o_timer_adj (timer_adj),
    .o_irq_ack   (irq_ack),
    .o_ipc_wr    (ipc_wr),
    .o_wbyte     (wbyte),
    .o_wbit      (wbit),
    .o_ack       (o_ack),
    .o_rdata     (o_rdata),
    .o_mode      (o_mode)
  );

  ql_rtc #(.PRESCALE(PRESCALE)) ql_rtc_inst (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_timer_clr (timer_clr),
    .i_timer_adj (timer_adj),
    .i_wbyte     (wbyte),
    .o_count     (count)
  );

  ql_irq_ctrl ql_irq_ctrl_inst (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_vsync     (i_vsync),
    .i_irq_ack   (irq_ack),
    .i_wbyte     (wbyte),
    .i_timer_lsb (count[0]),    // Timer bit in the pending byte
    .o_pending   (pending),
    .o_irq       (o_irq)
  );

  ql_ipc ql_ipc_inst (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_ipc_wr    (ipc_wr),
    .i_wbit      (wbit),
    .i_key_row   (key_row),
    .i_key_col   (key_col),
    .i_shift     (key_shift),
    .i_ctrl      (key_ctrl),
    .i_alt       (key_alt),
    .i_any_key   (any_key),
    .i_row_byte  (row_byte),
    .o_reply_bit (reply_bit),
    .o_row_sel   (row_sel)
  );

  ql_key_encoder ql_key_encoder_inst (
    .i_kbd_matrix (i_kbd_matrix),
    .i_row_sel    (row_sel),
    .o_key_row    (key_row),
    .o_key_col    (key_col),
    .o_shift      (key_shift),
    .o_ctrl       (key_ctrl),
    .o_alt        (key_alt),
    .o_any_key    (any_key),
    .o_row_byte   (row_byte)
  );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 40,   // ns
  parameter int RESET_CYCLES = 8
) (
  output logic clk_cpu,
  output logic reset
);

  initial clk_cpu = 1'b0;
  always #(PERIOD / 2) clk_cpu = ~clk_cpu;

  // Reset drops on a falling edge, like every other DUT input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_cpu);
    @(negedge clk_cpu);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/tb_ql_io.sv
`timescale 1ns/1ps
`default_nettype none
`include "ql_io_params.svh"

module tb_ql_io;
  import ql_io_pkg::*;

  typedef enum int {OP_WRITE, OP_READ, OP_VSYNC, OP_MATRIX, OP_WAIT, OP_PINS} op_e;

  localparam logic [6:0] TIMER_ADDR     = 7'(`QL_OFS_TIMER * 2);
  localparam logic [6:0] TIMER_LOW_ADDR = 7'(`QL_OFS_TIMER * 2 + 2);
  localparam logic [6:0] IPC_ADDR       = 7'(`QL_OFS_IPC * 2);
  localparam logic [6:0] IRQ_ADDR       = 7'(`QL_OFS_IRQ * 2);
  localparam logic [6:0] DISPLAY_ADDR   = 7'(`QL_OFS_DISPLAY * 2);
  localparam int         PRESCALE       = 64;

  logic                     clk_cpu;
  logic                     reset;
  logic                     i_req;
  logic                     i_wr;
  logic [`QL_IO_ADDR_W-1:0] i_addr;
  logic [1:0]               i_be;
  logic [`QL_DATA_W-1:0]    i_wdata;
  logic                     i_vsync;
  logic [`QL_KBD_W-1:0]     i_kbd_matrix;
  logic                     o_ack;
  logic [`QL_DATA_W-1:0]    o_rdata;
  logic                     o_irq;
  logic                     o_mode;

  // Stimulus table, one column per queue
  string       names[$];
  op_e         ops[$];
  logic [6:0]  addrs[$];
  logic [1:0]  bes[$];
  logic [63:0] datas[$];
  logic [15:0] exps[$];
  logic [15:0] masks[$];
  int          tols[$];

  int          table_cycles = 0;
  int          cycle_limit  = 0;
  int          cycles       = 0;
  int          err_cnt      = 0;
  logic [31:0] lfsr         = 32'h4e4d717d;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(8)) clock_gen_inst (
    .clk_cpu (clk_cpu),
    .reset   (reset)
  );

  ql_io_top #(.PRESCALE(PRESCALE)) ql_io_top_inst (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .i_req        (i_req),
    .i_wr         (i_wr),
    .i_addr       (i_addr),
    .i_be         (i_be),
    .i_wdata      (i_wdata),
    .i_vsync      (i_vsync),
    .i_kbd_matrix (i_kbd_matrix),
    .o_ack        (o_ack),
    .o_rdata      (o_rdata),
    .o_irq        (o_irq),
    .o_mode       (o_mode)
  );

  // ========================================
  // Random source and reference models
  // ========================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Galois, right shift
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);          // One step per bit
      v    = {v[62:0], lfsr[0]};
    end
  endtask

  // Read key reply word: 0, shift, ctrl, alt, 0, 0, row, col
  function automatic logic [11:0] key_word(input logic [63:0] m);
    logic [2:0] row;
    logic [2:0] col;
    logic       found;
    row   = 3'd7;                      // No key in rows 0..6
    found = 1'b0;
    for (int r = 0; r < 7; r++) begin
      if (!found && m[r*8 +: 8] != 8'h00) begin
        row   = 3'(r);
        found = 1'b1;
      end
    end
    col   = 3'd7;
    found = 1'b0;
    for (int c = 0; c < 7; c++) begin
      if (!found && m[int'(row)*8 + c]) begin
        col   = 3'(c);
        found = 1'b1;
      end
    end
    key_word = {1'b0, m[56], m[57], m[58], 2'b00, row, col};
  endfunction

  // ========================================
  // Table building
  // ========================================
  task automatic add_entry(input string nm, input op_e op, input logic [6:0] addr,
                           input logic [1:0] be, input logic [63:0] data,
                           input logic [15:0] exp, input logic [15:0] mask, input int tol);
    names.push_back(nm);
    ops.push_back(op);
    addrs.push_back(addr);
    bes.push_back(be);
    datas.push_back(data);
    exps.push_back(exp & mask);
    masks.push_back(mask);
    tols.push_back(tol);
    case (op)
      OP_WAIT:  table_cycles += int'(data);
      OP_VSYNC: table_cycles += 6;
      OP_PINS:  table_cycles += 0;
      default:  table_cycles += 1;
    endcase
  endtask

  // Command or parameter nibble, MSB first on data bit 1
  task automatic send_nibble(input string nm, input logic [3:0] nib);
    for (int b = 3; b >= 0; b--)
      add_entry($sformatf("%s_bit%0d", nm, 3 - b), OP_WRITE, IPC_ADDR, 2'b01,
                {62'b0, nib[b], 1'b0}, 16'h0, 16'h0, 0);
  endtask

  // Status bit 7 before every reply write
  task automatic expect_reply(input string nm, input logic [15:0] word, input int len);
    logic bit_exp;
    for (int i = 0; i < len; i++) begin
      bit_exp = word[len - 1 - i];
      add_entry($sformatf("%s_rd%0d", nm, i), OP_READ, IRQ_ADDR, 2'b11, 64'h0,
                {bit_exp, 15'b0}, 16'h8000, 0);
      add_entry($sformatf("%s_wr%0d", nm, i), OP_WRITE, IPC_ADDR, 2'b01, 64'h0,
                16'h0, 16'h0, 0);
    end
  endtask

  task automatic build_table();
    logic [63:0] m;
    logic [63:0] v;
    logic [2:0]  row;
    logic [2:0]  col;
    // After reset
    add_entry("reset_pins", OP_PINS, 7'h0, 2'b00, 64'h0, 16'h0001, 16'hffff, 0);
    add_entry("reset_irq_read", OP_READ, IRQ_ADDR, 2'b11, 64'h0, 16'h0, 16'hffff, 0);
    add_entry("mode_write", OP_WRITE, DISPLAY_ADDR, 2'b01, 64'h0, 16'h0, 16'h0, 0);
    add_entry("mode_pins", OP_PINS, 7'h0, 2'b00, 64'h0, 16'h0000, 16'h0001, 0);
    // Counter, clear then byte adjust from bits 7:0 up
    add_entry("timer_clear", OP_WRITE, TIMER_ADDR, 2'b10, 64'h0, 16'h0, 16'h0, 0);
    add_entry("timer_adj0", OP_WRITE, TIMER_ADDR, 2'b01, 64'h78, 16'h0, 16'h0, 0);
    add_entry("timer_adj1", OP_WRITE, TIMER_ADDR, 2'b01, 64'h56, 16'h0, 16'h0, 0);
    add_entry("timer_adj2", OP_WRITE, TIMER_ADDR, 2'b01, 64'h34, 16'h0, 16'h0, 0);
    add_entry("timer_adj3", OP_WRITE, TIMER_ADDR, 2'b01, 64'h12, 16'h0, 16'h0, 0);
    add_entry("timer_high", OP_READ, TIMER_ADDR, 2'b11, 64'h0, 16'h1234, 16'hffff, 0);
    add_entry("timer_low", OP_READ, TIMER_LOW_ADDR, 2'b11, 64'h0, 16'h5678, 16'hffff, 0);
    // Three prescale periods, two to four seconds counted
    add_entry("tick_wait", OP_WAIT, 7'h0, 2'b00, 64'(3 * PRESCALE), 16'h0, 16'h0, 0);
    add_entry("timer_ticks", OP_READ, TIMER_LOW_ADDR, 2'b11, 64'h0, 16'h5678 + 16'd3,
              16'hffff, 1);
    // Vsync interrupt
    add_entry("vsync_fall", OP_VSYNC, 7'h0, 2'b00, 64'h0, 16'h0001, 16'h0001, 0);
    add_entry("irq_pending", OP_READ, IRQ_ADDR, 2'b11, 64'h0, 16'h0008, 16'h0008, 0);
    add_entry("irq_ack", OP_WRITE, IRQ_ADDR, 2'b01, 64'h08, 16'h0, 16'h0, 0);
    add_entry("irq_cleared", OP_READ, IRQ_ADDR, 2'b11, 64'h0, 16'h0000, 16'h0008, 0);
    add_entry("irq_low", OP_PINS, 7'h0, 2'b00, 64'h0, 16'h0000, 16'h0002, 0);
    // Get status, any key down
    take_bits(64, m);
    if (m == 64'h0)
      m = 64'h1;
    add_entry("status_matrix", OP_MATRIX, 7'h0, 2'b00, m, 16'h0, 16'h0, 0);
    send_nibble("status_cmd", cmd_status);
    expect_reply("status_key", 16'h0080, 8);
    add_entry("status_empty", OP_MATRIX, 7'h0, 2'b00, 64'h0, 16'h0, 16'h0, 0);
    send_nibble("status_cmd2", cmd_status);
    expect_reply("status_none", 16'h0000, 8);
    // Read key, shift plus one key in rows 0..6
    take_bits(3, v);
    while (v[2:0] == 3'd7)
      take_bits(3, v);
    row = v[2:0];
    take_bits(3, v);
    col = v[2:0];
    m   = (64'h1 << 56) | (64'h1 << (int'(row) * 8 + int'(col)));
    add_entry("key_matrix", OP_MATRIX, 7'h0, 2'b00, m, 16'h0, 16'h0, 0);
    send_nibble("key_cmd", cmd_key);
    expect_reply("key_word", {4'b0, key_word(m)}, 12);
    // Read key row with a random row number
    take_bits(64, m);
    take_bits(3, v);
    row = v[2:0];
    add_entry("keyrow_matrix", OP_MATRIX, 7'h0, 2'b00, m, 16'h0, 16'h0, 0);
    send_nibble("keyrow_cmd", cmd_keyrow);
    send_nibble("keyrow_param", {1'b0, row});
    expect_reply("keyrow_byte", {8'h0, m[int'(row)*8 +: 8]}, 8);
  endtask

  // ========================================
  // Checking and applying
  // ========================================
  task automatic stop_run();
    err_cnt++;
    $display("Done: errors found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string nm, input logic [15:0] exp, input logic [15:0] mask,
                             input int tol, input logic [15:0] value);
    logic [15:0] act;
    int          diff;
    act  = value & mask;
    diff = (act > exp) ? int'(act - exp) : int'(exp - act);
    assert (diff <= tol) else begin
      $display("Fail %s expected %h actual %h", nm, exp, act);
      stop_run();
    end
  endtask

  task automatic apply_entry(input int idx);
    logic [15:0] rd;
    case (ops[idx])
      OP_WRITE, OP_READ: begin
        i_req   = 1'b1;
        i_wr    = (ops[idx] == OP_WRITE);
        i_addr  = addrs[idx];
        i_be    = bes[idx];
        i_wdata = datas[idx][15:0];
        @(negedge clk_cpu);
        assert (o_ack) else begin
          $display("No acknowledge in the cycle after the request of %s", names[idx]);
          stop_run();
        end
        rd    = o_rdata;
        i_req = 1'b0;
        i_wr  = 1'b0;
        if (ops[idx] == OP_READ)
          check_value(names[idx], exps[idx], masks[idx], tols[idx], rd);
      end
      OP_VSYNC: begin
        i_vsync = 1'b1;
        repeat (3) @(negedge clk_cpu);
        i_vsync = 1'b0;                // Falling edge
        repeat (3) @(negedge clk_cpu);
        check_value(names[idx], exps[idx], masks[idx], tols[idx], {15'b0, o_irq});
      end
      OP_MATRIX: begin
        i_kbd_matrix = datas[idx];
        @(negedge clk_cpu);
      end
      OP_WAIT: repeat (int'(datas[idx])) @(negedge clk_cpu);
      default: check_value(names[idx], exps[idx], masks[idx], tols[idx],
                           {14'b0, o_irq, o_mode});
    endcase
  endtask

  // Watchdog
  always @(posedge clk_cpu) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      err_cnt++;
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Done: errors found");
      $fatal(1, "Run stopped by the watchdog");
    end
  end

  initial begin
    i_req        = 1'b0;
    i_wr         = 1'b0;
    i_addr       = '0;
    i_be         = 2'b00;
    i_wdata      = '0;
    i_vsync      = 1'b0;
    i_kbd_matrix = '0;
    build_table();
    cycle_limit = 8 + table_cycles + 100;   // Reset, table, margin
    @(posedge clk_cpu);
    while (reset)
      @(posedge clk_cpu);                   // Reset changes on falling edges
    @(negedge clk_cpu);
    for (int i = 0; i < ops.size(); i++)
      apply_entry(i);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ql_io_top.f
+incdir+rtl
rtl/ql_io_pkg.sv
rtl/ql_bus_decode.sv
rtl/ql_rtc.sv
rtl/ql_irq_ctrl.sv
rtl/ql_ipc.sv
rtl/ql_key_encoder.sv
rtl/ql_io_top.sv
dv/tb_clock_gen.sv
dv/tb_ql_io.sv
